//--- flist.f
+incdir+.
sram_pkg.sv
sram_beat_timer.sv
sram_sequencer.sv
sram_data_path.sv
sram_ctrl.sv
tb_clock_gen.sv
tb_sram_model.sv
tb_sram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the SRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_sram_ctrl -f flist.f --Mdir obj_dir -o tb_sram_ctrl
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sram_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

//--- sram_beat_timer.sv
`timescale 1ns/100ps
`include "sram_consts.svh"

module sram_beat_timer (
  input  logic clock,
  input  logic reset,
  input  logic run,
  output logic beat_done
);

  localparam int count_width = $clog2(`SRAM_BEAT_CYCLES + 1);
  localparam logic [count_width-1:0] last_count = count_width'(`SRAM_BEAT_CYCLES - 1);

  logic [count_width-1:0] count;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
    end else if (!run || count == last_count) begin
      count <= '0; // idle or wrapping into the next beat
    end else begin
      count <= count + 1'b1;
    end
  end

  // the counter only leaves zero while run is high
  assign beat_done = (count == last_count);

  // a stray beat_done outside a transfer would step the sequencer or corrupt a capture
  no_beat_when_idle: assert property (
    @(posedge clock) disable iff (!reset)
    !run |-> !beat_done
  );

endmodule

//--- sram_consts.svh
`ifndef SRAM_CONSTS_SVH
`define SRAM_CONSTS_SVH

// clock cycles per 16-bit beat
// needs to be at least 2 so the read pins settle before the capture edge
`define SRAM_BEAT_CYCLES 4

// halfword data bus of the external part
`define SRAM_DQ_WIDTH 16

// 256K halfwords
`define SRAM_ADDR_WIDTH 18

`define SRAM_BEATS 4 // halfwords per processor word

`define SRAM_WORD_WIDTH 64

`endif

//--- sram_ctrl.sv
`timescale 1ns/100ps
`include "sram_consts.svh"

module sram_ctrl (
  input  logic                        clock,
  input  logic                        reset,
  input  sram_pkg::mem_req_t          req,
  output sram_pkg::mem_rsp_t          rsp,
  output logic                        sram_ce_n,
  output logic                        sram_we_n,
  output logic                        sram_oe_n,
  output logic                        sram_ub_n,
  output logic                        sram_lb_n,
  output logic [`SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [`SRAM_DQ_WIDTH-1:0]   sram_dq
);

  import sram_pkg::*;

  logic                        run;
  logic                        beat_done;
  logic                        accept;
  logic                        writing;
  logic                        reading;
  logic                        ready;
  beat_t                       beat;
  logic [`SRAM_WORD_WIDTH-1:0] rdata;
  logic [`SRAM_DQ_WIDTH-1:0]   dq_out;

  sram_beat_timer u_timer (
    .clock     (clock),
    .reset     (reset),
    .run       (run),
    .beat_done (beat_done)
  );

  sram_sequencer u_sequencer (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req.valid),
    .req_write (|req.wstrb), // any strobe set makes it a write
    .beat_done (beat_done),
    .accept    (accept),
    .run       (run),
    .writing   (writing),
    .reading   (reading),
    .beat      (beat),
    .last_beat (),
    .ready     (ready)
  );

  sram_data_path u_data_path (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .accept    (accept),
    .writing   (writing),
    .reading   (reading),
    .beat      (beat),
    .beat_done (beat_done),
    .rdata     (rdata),
    .ce_n      (sram_ce_n),
    .we_n      (sram_we_n),
    .oe_n      (sram_oe_n),
    .ub_n      (sram_ub_n),
    .lb_n      (sram_lb_n),
    .sram_addr (sram_addr),
    .dq_out    (dq_out),
    .dq_in     (sram_dq)
  );

  // the controller owns dq only while a write strobe is on the pins
  assign sram_dq = !sram_we_n ? dq_out : 'z;

  assign rsp = '{ready: ready, rdata: rdata};

endmodule

//--- sram_data_path.sv
`timescale 1ns/100ps
`include "sram_consts.svh"

module sram_data_path (
  input  logic                        clock,
  input  logic                        reset,
  input  sram_pkg::mem_req_t          req,
  input  logic                        accept,
  input  logic                        writing,
  input  logic                        reading,
  input  sram_pkg::beat_t             beat,
  input  logic                        beat_done,
  output logic [`SRAM_WORD_WIDTH-1:0] rdata,
  output logic                        ce_n,
  output logic                        we_n,
  output logic                        oe_n,
  output logic                        ub_n,
  output logic                        lb_n,
  output logic [`SRAM_ADDR_WIDTH-1:0] sram_addr,
  output logic [`SRAM_DQ_WIDTH-1:0]   dq_out,
  input  logic [`SRAM_DQ_WIDTH-1:0]   dq_in
);

  import sram_pkg::*;

  logic [`SRAM_ADDR_WIDTH-3:0] base_addr; // byte address bits 18:3
  logic [7:0]                  strb_q;
  sram_word_u                  wword;
  sram_word_u                  rword;

  always_ff @(posedge clock) begin
    if (accept) begin
      base_addr   <= req.addr[18:3];
      strb_q      <= req.wstrb;
      wword.whole <= req.wdata;
    end
    // the pins have shown this beat's address since early in the beat
    if (reading && beat_done) begin
      rword.half[beat] <= dq_in;
    end
  end

  // address and write lane for the current beat, one cycle behind the sequencer
  always_ff @(posedge clock) begin
    sram_addr <= {base_addr, beat};
    dq_out    <= wword.half[beat];
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ce_n <= 1'b1;
      we_n <= 1'b1;
      oe_n <= 1'b1;
      ub_n <= 1'b1;
      lb_n <= 1'b1;
    end else begin
      ce_n <= !(writing || reading);
      we_n <= !writing;
      oe_n <= !reading;
      // writes take the strobe pair of this halfword, reads enable both bytes
      ub_n <= writing ? !strb_q[{beat, 1'b1}] : !reading;
      lb_n <= writing ? !strb_q[{beat, 1'b0}] : !reading;
    end
  end

  assign rdata = rword.whole;

  // both low would have the controller and the SRAM fighting over dq
  no_bus_fight: assert property (
    @(posedge clock) disable iff (!reset)
    !(!we_n && !oe_n)
  );

endmodule

//--- sram_pkg.sv
`include "sram_consts.svh"

package sram_pkg;

  typedef logic [1:0] beat_t; // which halfword of the word is on the bus

  typedef struct packed {
    logic                        valid;
    logic [31:0]                 addr; // byte address
    logic [`SRAM_WORD_WIDTH-1:0] wdata;
    logic [7:0]                  wstrb; // all zero means a read
  } mem_req_t;

  typedef struct packed {
    logic                        ready;
    logic [`SRAM_WORD_WIDTH-1:0] rdata;
  } mem_rsp_t;

  // the port sees whole words, the SRAM side works one halfword at a time
  typedef union packed {
    logic [`SRAM_WORD_WIDTH-1:0]                 whole;
    logic [`SRAM_BEATS-1:0][`SRAM_DQ_WIDTH-1:0] half;
  } sram_word_u;

endpackage

//--- sram_sequencer.sv
`timescale 1ns/100ps

module sram_sequencer (
  input  logic            clock,
  input  logic            reset,
  input  logic            req_valid,
  input  logic            req_write,
  input  logic            beat_done,
  output logic            accept,
  output logic            run,
  output logic            writing,
  output logic            reading,
  output sram_pkg::beat_t beat,
  output logic            last_beat,
  output logic            ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_transfer,
    st_done
  } state_t;

  state_t state;
  logic   write_q; // direction of the request in flight

  assign accept    = (state == st_idle) && req_valid; // valid while busy is dropped
  assign run       = (state == st_transfer);
  assign writing   = run && write_q;
  assign reading   = run && !write_q;
  assign last_beat = run && (beat == 2'd3);
  assign ready     = (state == st_done);

  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= st_idle;
      write_q <= 1'b0;
      beat    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_transfer;
            write_q <= req_write;
            beat    <= '0;
          end
        end
        st_transfer: begin
          if (beat_done) begin
            if (last_beat) begin
              state <= st_done;
            end else begin
              beat <= beat + 2'd1;
            end
          end
        end
        st_done: begin
          state <= st_idle; // one cycle of ready, then free again
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  dir_exclusive: assert property (
    @(posedge clock) disable iff (!reset)
    !(writing && reading)
  );

  // the requester relies on a single ready per request
  ready_pulse: assert property (
    @(posedge clock) disable iff (!reset)
    ready |=> !ready
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock
);

  // 100 ns period, first rising edge at 50 ns
  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

endmodule

//--- tb_sram_ctrl.sv
`timescale 1ns/100ps
`include "sram_consts.svh"

module tb_sram_ctrl;

  import sram_pkg::*;

  localparam int ready_timeout = 4 * `SRAM_BEAT_CYCLES + 10;
  localparam int unsigned seed = 27275;

  logic        clock;
  logic        reset;
  mem_req_t    req;
  mem_rsp_t    rsp;
  logic        sram_ce_n;
  logic        sram_we_n;
  logic        sram_oe_n;
  logic        sram_ub_n;
  logic        sram_lb_n;
  logic [17:0] sram_addr;
  wire  [15:0] sram_dq;

  logic [63:0] shadow [0:65535]; // one word per byte-address bits 18:3
  logic [1:0]  beat_seq[$];
  logic [15:0] expect_hi;
  bit          track_beats;
  int          errors;
  int          passes;
  int          test_errors;

  tb_clock_gen clock_gen (
    .clock (clock)
  );

  sram_ctrl UUT (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .rsp       (rsp),
    .sram_ce_n (sram_ce_n),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ub_n (sram_ub_n),
    .sram_lb_n (sram_lb_n),
    .sram_addr (sram_addr),
    .sram_dq   (sram_dq)
  );

  tb_sram_model sram_model (
    .ce_n (sram_ce_n),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ub_n (sram_ub_n),
    .lb_n (sram_lb_n),
    .addr (sram_addr),
    .dq   (sram_dq)
  );

  // same contents the SRAM model starts with
  function automatic logic [15:0] fill_half(logic [17:0] a);
    return a[15:0] ^ {a[17:16], 14'h0a5c};
  endfunction

  function automatic logic [63:0] merge_word(logic [63:0] old_w, logic [63:0] new_w,
                                             logic [7:0] strb);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return m;
  endfunction

  function automatic logic [63:0] expected_word(logic [31:0] addr);
    return shadow[addr[18:3]];
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // one cycle of valid, so the request cannot be taken twice
  task automatic send_request(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb);
    @(negedge clock);
    req.valid = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    req.wstrb = strb;
    @(negedge clock);
    req.valid = 1'b0;
  endtask

  task automatic wait_ready(output bit seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    beat_seq.delete();
    while (!seen && cycles < ready_timeout) begin
      @(negedge clock);
      cycles++;
      check_value("sram_we_n|sram_oe_n", 64'(sram_we_n | sram_oe_n), 64'd1);
      if (track_beats && !sram_ce_n) begin
        check_value("sram_addr[17:2]", 64'(sram_addr[17:2]), 64'(expect_hi));
        if (beat_seq.size() == 0 || beat_seq[$] != sram_addr[1:0]) begin
          beat_seq.push_back(sram_addr[1:0]);
        end
      end
      seen = rsp.ready;
    end
    if (!seen) begin
      $display("timeout: no ready pulse within %0d cycles of the request", ready_timeout);
      errors++;
    end
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb);
    bit seen;
    send_request(addr, data, strb);
    wait_ready(seen);
    shadow[addr[18:3]] = merge_word(shadow[addr[18:3]], data, strb);
  endtask

  task automatic read_and_check(input logic [31:0] addr);
    bit seen;
    send_request(addr, 64'd0, 8'd0);
    wait_ready(seen);
    check_value("rsp.rdata", rsp.rdata, expected_word(addr));
  endtask

  task automatic check_beats();
    check_value("beat count", 64'(beat_seq.size()), 64'd4);
    foreach (beat_seq[i]) begin
      check_value("sram_addr[1:0]", 64'(beat_seq[i]), 64'(i));
    end
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] addr_b;
    logic [7:0]  strb;
    int          ready_count;
    bit          seen;

    void'($urandom(seed));
    errors = 0;
    passes = 0;
    test_errors = 0;
    track_beats = 1'b0;
    expect_hi = '0;
    reset = 1'b0;
    req = '0;
    for (int w = 0; w < 65536; w++) begin
      shadow[w] = {fill_half({16'(w), 2'd3}), fill_half({16'(w), 2'd2}),
                   fill_half({16'(w), 2'd1}), fill_half({16'(w), 2'd0})};
    end
    repeat (2) @(negedge clock);
    reset = 1'b1;

    repeat (4) begin
      @(negedge clock);
      check_value("{ce_n,we_n,oe_n,ub_n,lb_n}",
                  64'({sram_ce_n, sram_we_n, sram_oe_n, sram_ub_n, sram_lb_n}), 64'h1f);
      check_value("rsp.ready", 64'(rsp.ready), 64'd0);
    end
    report_test("reset state");

    addr = 32'h0001_2340;
    do_write(addr, 64'h0123_4567_89ab_cdef, 8'hff);
    read_and_check(addr);
    report_test("full write and read");

    do_write(addr, 64'hfedc_ba98_7654_3210, 8'ha5);
    read_and_check(addr);
    report_test("partial strobe write");

    addr = 32'h0007_fff8; // top word, every base bit set
    expect_hi = addr[18:3];
    track_beats = 1'b1;
    do_write(addr, 64'h1111_2222_3333_4444, 8'h3c);
    check_beats();
    read_and_check(addr);
    check_beats();
    track_beats = 1'b0;
    report_test("beat order");

    // sixteen word slots so reads often land on earlier writes
    repeat (50) begin
      addr = ($urandom & 32'hfff8_0007) | (($urandom % 16) << 3);
      if ($urandom % 2 == 1) begin
        strb = 8'($urandom);
        do_write(addr, {$urandom, $urandom}, (strb == 8'd0) ? 8'hff : strb);
      end else begin
        read_and_check(addr);
      end
    end
    report_test("random traffic");

    addr   = 32'h0000_0100;
    addr_b = 32'h0000_0200;
    send_request(addr, 64'hcafe_f00d_dead_beef, 8'hff);
    repeat (3) @(negedge clock);
    req.valid = 1'b1;
    req.addr  = addr_b;
    req.wdata = 64'h5555_aaaa_5555_aaaa;
    req.wstrb = 8'hff;
    @(negedge clock);
    req.valid = 1'b0;
    wait_ready(seen);
    ready_count = seen ? 1 : 0;
    repeat (2 * ready_timeout) begin
      @(negedge clock);
      if (rsp.ready) begin
        ready_count++;
      end
    end
    check_value("ready pulses", 64'(ready_count), 64'd1);
    shadow[addr[18:3]] = merge_word(shadow[addr[18:3]], 64'hcafe_f00d_dead_beef, 8'hff);
    read_and_check(addr);
    read_and_check(addr_b);
    report_test("request while busy");

    $display("%0d checks passed, %0d errors", passes, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tb_sram_model.sv
`timescale 1ns/100ps

module tb_sram_model (
  input  logic        ce_n,
  input  logic        we_n,
  input  logic        oe_n,
  input  logic        ub_n,
  input  logic        lb_n,
  input  logic [17:0] addr,
  inout  wire  [15:0] dq
);

  logic [15:0] mem [0:(1 << 18) - 1];

  // initial contents vary with every address bit
  initial begin
    for (int i = 0; i < (1 << 18); i++) begin
      mem[i] = 16'(i) ^ {2'(i >> 16), 14'h0a5c};
    end
  end

  // the pins all move on one clock edge, so look again once they have settled
  always begin
    @(ce_n or we_n or ub_n or lb_n or addr or dq);
    #1;
    if (!ce_n && !we_n) begin
      if (!ub_n) begin
        mem[addr][15:8] = dq[15:8];
      end
      if (!lb_n) begin
        mem[addr][7:0] = dq[7:0];
      end
    end
  end

  assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z; // read drive

endmodule
